// ==== sim.f ====
+incdir+.
soc_pkg.sv
bus_mapper.sv
mult_unit.sv
interval_timer.sv
readback_led_port.sv
soc_core.sv
tb_soc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_soc
FILELIST  := sim.f
PASS_MSG  := Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"
`default_nettype none

module tb_soc import soc_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 8;
    localparam int MULT_PAIRS  = 4;
    localparam int RELOAD_ONE  = 5;
    localparam int RELOAD_AUTO = 3;    // at least 2 so a status read fits between two expiries
    localparam int MAX_RELOAD  = (RELOAD_ONE > RELOAD_AUTO) ? RELOAD_ONE : RELOAD_AUTO;
    localparam int WD_MARGIN   = 40;   // reset cycles plus some slack

    // with the identity map a CPU address is the low 16 bits of the mapped address
    localparam logic [15:0] MAP_BASE  = `SOC_MAP_BASE;
    localparam logic [15:0] MULT_BASE = 16'(`SOC_MULT_BASE);
    localparam logic [15:0] TMR_BASE  = 16'(`SOC_TIMER_BASE);
    localparam logic [15:0] LEDS_ADDR = 16'(`SOC_LEDS_ADDR);

    typedef enum logic [1:0] {CHK_NONE, CHK_RDATA, CHK_LEDS, CHK_IRQB} chk_e;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rwb;
        logic        valid;
        logic [7:0]  exp;
        chk_e        chk;
    } row_t;

    logic       clk_cpu;
    logic       i_rst;
    bus_req_t   bus_req;
    logic [7:0] o_rdata;
    logic [7:0] o_leds;
    logic       o_irqb;

    row_t  rows[$];
    int    test_end[$];
    string test_name[$];
    int    test_errors;
    int    total_errors;
    int    tests_failed;
    bit    rows_built;

    soc_core i_dut (
        .clk_cpu (clk_cpu),
        .i_rst   (i_rst),
        .i_bus   (bus_req),
        .o_rdata (o_rdata),
        .o_leds  (o_leds),
        .o_irqb  (o_irqb)
    );

    always #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;

    function automatic void push_row(input logic [15:0] addr, input logic [7:0] data,
                                     input logic rwb, input logic valid,
                                     input logic [7:0] exp, input chk_e chk);
        rows.push_back(row_t'({addr, data, rwb, valid, exp, chk}));
    endfunction

    function automatic void write_row(input logic [15:0] addr, input logic [7:0] data);
        push_row(addr, data, 1'b0, 1'b1, 8'h00, CHK_NONE);
    endfunction

    function automatic void read_row(input logic [15:0] addr, input logic [7:0] exp);
        push_row(addr, 8'h00, 1'b1, 1'b1, exp, CHK_RDATA);
    endfunction

    // idle bus cycle that looks at o_leds or o_irqb instead of the read data
    function automatic void idle_row(input chk_e chk, input logic [7:0] exp);
        push_row(16'h0000, 8'h00, 1'b1, 1'b0, exp, chk);
    endfunction

    function automatic void close_test(input string name);
        test_name.push_back(name);
        test_end.push_back(rows.size());
    endfunction

    function automatic void build_tests();
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [31:0] prod;
        for (int n = 0; n < 16; n++) begin
            read_row(MAP_BASE + 16'(n), 8'(n));    // identity map out of reset
        end
        idle_row(CHK_LEDS, 8'h00);
        idle_row(CHK_IRQB, 8'h01);
        read_row(TMR_BASE + 16'd3, 8'h00);
        close_test("reset defaults");

        write_row(LEDS_ADDR, 8'ha5);
        idle_row(CHK_LEDS, 8'ha5);
        read_row(LEDS_ADDR, 8'ha5);
        write_row(LEDS_ADDR, 8'h3c);
        idle_row(CHK_LEDS, 8'h3c);
        read_row(16'h1234, `SOC_OPEN_BUS);
        close_test("led port and open bus");

        for (int p = 0; p < MULT_PAIRS; p++) begin
            op_a = (p == 0) ? 16'hffff : 16'($urandom());    // first pair fills all 32 bits
            op_b = (p == 0) ? 16'hffff : 16'($urandom());
            prod = {16'h0000, op_a} * {16'h0000, op_b};
            write_row(MULT_BASE, op_a[7:0]);
            write_row(MULT_BASE + 16'd1, op_a[15:8]);
            write_row(MULT_BASE + 16'd2, op_b[7:0]);
            write_row(MULT_BASE + 16'd3, op_b[15:8]);
            read_row(MULT_BASE + 16'd1, op_a[15:8]);    // product still on its way here
            for (int k = 0; k < 4; k++) begin
                read_row(MULT_BASE + 16'(4 + k), prod[8*k +: 8]);
            end
        end
        close_test("multiplier");

        read_row(16'h3fff, `SOC_OPEN_BUS);
        write_row(MAP_BASE + 16'd3, 8'h0e);    // page 3 now points at the device page
        read_row(MAP_BASE + 16'd3, 8'h0e);
        write_row(16'h3fff, 8'h5a);
        idle_row(CHK_LEDS, 8'h5a);
        read_row(LEDS_ADDR, 8'h5a);
        read_row(16'h3ff0, op_a[7:0]);
        read_row(16'h3ff4, prod[7:0]);
        write_row(MAP_BASE + 16'd3, 8'h03);
        read_row(16'h3fff, `SOC_OPEN_BUS);
        read_row(16'h3ff0, `SOC_OPEN_BUS);
        close_test("mapper remap");

        write_row(TMR_BASE, 8'(RELOAD_ONE));
        write_row(TMR_BASE + 16'd1, 8'h00);
        write_row(TMR_BASE + 16'd2, 8'h03);    // enable and interrupt, no auto-reload
        for (int c = 0; c <= RELOAD_ONE; c++) begin
            idle_row(CHK_IRQB, 8'h01);
        end
        idle_row(CHK_IRQB, 8'h00);    // reload + 1 cycles after the control write edge
        read_row(TMR_BASE + 16'd3, 8'h01);
        idle_row(CHK_IRQB, 8'h01);
        read_row(TMR_BASE + 16'd3, 8'h00);
        close_test("timer one-shot");

        write_row(TMR_BASE, 8'(RELOAD_AUTO));
        write_row(TMR_BASE + 16'd2, 8'h07);
        // first expiry counts from the control write, the next one from the previous expiry
        for (int e = 0; e < 2; e++) begin
            for (int c = 0; c < ((e == 0) ? RELOAD_AUTO + 1 : RELOAD_AUTO - 1); c++) begin
                idle_row(CHK_IRQB, 8'h01);
            end
            idle_row(CHK_IRQB, 8'h00);
            read_row(TMR_BASE + 16'd3, 8'h01);
        end
        write_row(TMR_BASE + 16'd2, 8'h00);
        read_row(TMR_BASE + 16'd3, 8'h00);
        idle_row(CHK_IRQB, 8'h01);
        close_test("timer auto-reload");
    endfunction

    task automatic check_row(input row_t r);
        case (r.chk)
            CHK_RDATA: begin
                assert (o_rdata === r.exp) else begin
                    $display("Error: o_rdata at addr 0x%04h expected 0x%02h actual 0x%02h",
                             r.addr, r.exp, o_rdata);
                    test_errors++;
                end
            end
            CHK_LEDS: begin
                assert (o_leds === r.exp) else begin
                    $display("Error: o_leds expected 0x%02h actual 0x%02h", r.exp, o_leds);
                    test_errors++;
                end
            end
            CHK_IRQB: begin
                assert (o_irqb === r.exp[0]) else begin
                    $display("Error: o_irqb at %0t expected 0x%01h actual 0x%01h",
                             $time, r.exp[0], o_irqb);
                    test_errors++;
                end
            end
            default: ;
        endcase
    endtask

    task automatic apply_table();
        int t;
        t = 0;
        test_errors = 0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk_cpu);
            bus_req.addr  <= rows[i].addr;
            bus_req.wdata <= rows[i].wdata;
            bus_req.rwb   <= rows[i].rwb;
            bus_req.valid <= rows[i].valid;
            @(negedge clk_cpu);    // outputs are settled mid-cycle
            check_row(rows[i]);
            if (i + 1 == test_end[t]) begin
                $display("test %0d %s: %s, %0d errors", t, test_name[t],
                         (test_errors == 0) ? "ok" : "FAILED", test_errors);
                if (test_errors != 0) begin
                    tests_failed++;
                end
                total_errors += test_errors;
                test_errors = 0;
                t++;
            end
        end
        @(posedge clk_cpu);
        bus_req.valid <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'haee5ce46));
        clk_cpu      = 1'b0;
        i_rst        = 1'b1;
        bus_req      = '0;
        total_errors = 0;
        tests_failed = 0;
        rows_built   = 1'b0;
        build_tests();
        rows_built = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_cpu);
        i_rst <= 1'b0;
        apply_table();
        $display("%0d tests, %0d failed, %0d errors", test_name.size(), tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (rows_built);
        #((rows.size() + MAX_RELOAD + WD_MARGIN) * CLK_PERIOD);
        $display("Watchdog timeout: the stimulus table did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_core import soc_pkg::*; (
    input  logic       clk_cpu,
    input  logic       i_rst,
    input  bus_req_t   i_bus,
    output logic [7:0] o_rdata,
    output logic [7:0] o_leds,
    output logic       o_irqb
);

    dev_access_t acc;
    logic [7:0]  map_rdata;
    logic [7:0]  mult_rdata;
    logic [7:0]  timer_rdata;

    bus_mapper u_mapper (
        .clk_cpu (clk_cpu),
        .i_rst   (i_rst),
        .i_bus   (i_bus),
        .o_acc   (acc),
        .o_rdata (map_rdata)
    );

    mult_unit u_mult (
        .clk_cpu (clk_cpu),
        .i_rst   (i_rst),
        .i_acc   (acc),
        .o_rdata (mult_rdata)
    );

    interval_timer u_timer (
        .clk_cpu (clk_cpu),
        .i_rst   (i_rst),
        .i_acc   (acc),
        .o_rdata (timer_rdata),
        .o_irqb  (o_irqb)
    );

    readback_led_port u_readback (
        .clk_cpu       (clk_cpu),
        .i_rst         (i_rst),
        .i_acc         (acc),
        .i_map_rdata   (map_rdata),
        .i_mult_rdata  (mult_rdata),
        .i_timer_rdata (timer_rdata),
        .o_rdata       (o_rdata),
        .o_leds        (o_leds)
    );

endmodule

`default_nettype wire

// ==== readback_led_port.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"
`default_nettype none

module readback_led_port import soc_pkg::*; (
    input  logic        clk_cpu,
    input  logic        i_rst,
    input  dev_access_t i_acc,
    input  logic [7:0]  i_map_rdata,
    input  logic [7:0]  i_mult_rdata,
    input  logic [7:0]  i_timer_rdata,
    output logic [7:0]  o_rdata,
    output logic [7:0]  o_leds
);

    logic [7:0] leds_q;

    always_ff @(posedge clk_cpu) begin
        if (i_rst) begin
            leds_q <= 8'h00;
        end else if (i_acc.wr && (i_acc.sel == DEV_LEDS)) begin
            leds_q <= i_acc.wdata;
        end
    end

    assign o_leds = leds_q;

    // the mapper has already decided who answers, this is only a mux
    always_comb begin
        case (i_acc.sel)
            DEV_MAPPER: o_rdata = i_map_rdata;
            DEV_MULT:   o_rdata = i_mult_rdata;
            DEV_TIMER:  o_rdata = i_timer_rdata;
            DEV_LEDS:   o_rdata = leds_q;
            default:    o_rdata = `SOC_OPEN_BUS;
        endcase
    end

endmodule

`default_nettype wire

// ==== interval_timer.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"
`default_nettype none

module interval_timer import soc_pkg::*; (
    input  logic        clk_cpu,
    input  logic        i_rst,
    input  dev_access_t i_acc,
    output logic [7:0]  o_rdata,
    output logic        o_irqb
);

    timer_state_e state_q;
    logic [15:0]  reload_q;
    logic [15:0]  count_q;
    logic         ctrl_en_q;
    logic         ctrl_ie_q;
    logic         ctrl_ar_q;
    logic         expired_q;
    logic         tmr_wr;
    logic         ctrl_wr;
    logic         start;
    logic         status_rd;
    logic         expire;

    assign tmr_wr    = i_acc.wr && (i_acc.sel == DEV_TIMER);
    assign ctrl_wr   = tmr_wr && (i_acc.offset == 4'd2);
    assign start     = ctrl_wr && i_acc.wdata[`SOC_TMR_CTRL_EN];
    assign status_rd = i_acc.rd && (i_acc.sel == DEV_TIMER) && (i_acc.offset == 4'd3);
    assign expire    = (state_q == TMR_RUN) && (count_q == 16'h0000);

    always_ff @(posedge clk_cpu) begin
        if (i_rst) begin
            reload_q  <= 16'h0000;
            ctrl_en_q <= 1'b0;
            ctrl_ie_q <= 1'b0;
            ctrl_ar_q <= 1'b0;
        end else if (tmr_wr) begin
            case (i_acc.offset)
                4'd0: reload_q[7:0]  <= i_acc.wdata;
                4'd1: reload_q[15:8] <= i_acc.wdata;
                4'd2: begin
                    ctrl_en_q <= i_acc.wdata[`SOC_TMR_CTRL_EN];
                    ctrl_ie_q <= i_acc.wdata[`SOC_TMR_CTRL_IE];
                    ctrl_ar_q <= i_acc.wdata[`SOC_TMR_CTRL_AR];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (i_rst) begin
            state_q   <= TMR_IDLE;
            expired_q <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                state_q <= start ? TMR_RUN : TMR_IDLE;
            end else begin
                case (state_q)
                    TMR_RUN: begin
                        if (expire && !ctrl_ar_q) begin
                            state_q <= TMR_EXPIRED;
                        end
                    end
                    TMR_EXPIRED: begin
                        if (status_rd) begin
                            state_q <= TMR_IDLE;    // one-shot is done once software has seen it
                        end
                    end
                    default: state_q <= TMR_IDLE;
                endcase
            end
            // a new expiry wins over a clearing read in the same cycle
            if (expire && !ctrl_wr) begin
                expired_q <= 1'b1;
            end else if (status_rd) begin
                expired_q <= 1'b0;
            end
        end
    end

    // zero is counted too, so a reload of R expires after R + 1 edges
    always_ff @(posedge clk_cpu) begin
        if (start) begin
            count_q <= reload_q;
        end else if (state_q == TMR_RUN) begin
            count_q <= (count_q == 16'h0000) ? reload_q : count_q - 16'd1;
        end
    end

    assign o_irqb = !(expired_q && ctrl_ie_q);

    always_comb begin
        case (i_acc.offset)
            4'd0:    o_rdata = reload_q[7:0];
            4'd1:    o_rdata = reload_q[15:8];
            4'd2:    o_rdata = {5'b00000, ctrl_ar_q, ctrl_ie_q, ctrl_en_q};
            4'd3:    o_rdata = {7'b0000000, expired_q};
            default: o_rdata = 8'h00;
        endcase
    end

    // an expiry with the interrupt enabled pulls o_irqb low on the next cycle
    a_expiry_drives_irq: assert property (
        @(posedge clk_cpu) disable iff (i_rst)
        $past(expire) && !$past(ctrl_wr) && ctrl_ie_q |-> !o_irqb
    );

endmodule

`default_nettype wire

// ==== mult_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_unit import soc_pkg::*; (
    input  logic        clk_cpu,
    input  logic        i_rst,
    input  dev_access_t i_acc,
    output logic [7:0]  o_rdata
);

    logic [15:0] op_a_q;
    logic [15:0] op_b_q;
    logic [31:0] product_q;
    logic        op_wr;
    logic        pending_q;

    // offsets 0..3 are the operand bytes, everything above is read only
    assign op_wr = i_acc.wr && (i_acc.sel == DEV_MULT) && (i_acc.offset < 4'd4);

    always_ff @(posedge clk_cpu) begin
        if (op_wr) begin
            case (i_acc.offset[1:0])
                2'd0: op_a_q[7:0]  <= i_acc.wdata;
                2'd1: op_a_q[15:8] <= i_acc.wdata;
                2'd2: op_b_q[7:0]  <= i_acc.wdata;
                2'd3: op_b_q[15:8] <= i_acc.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (i_rst) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= op_wr;    // a new write simply restarts the update
        end
    end

    // the multiply sees the operands after the write edge has settled
    always_ff @(posedge clk_cpu) begin
        if (pending_q) begin
            product_q <= 32'(op_a_q) * 32'(op_b_q);
        end
    end

    always_comb begin
        case (i_acc.offset)
            4'd0:    o_rdata = op_a_q[7:0];
            4'd1:    o_rdata = op_a_q[15:8];
            4'd2:    o_rdata = op_b_q[7:0];
            4'd3:    o_rdata = op_b_q[15:8];
            4'd4:    o_rdata = product_q[7:0];
            4'd5:    o_rdata = product_q[15:8];
            4'd6:    o_rdata = product_q[23:16];
            4'd7:    o_rdata = product_q[31:24];
            default: o_rdata = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// ==== bus_mapper.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"
`default_nettype none

module bus_mapper import soc_pkg::*; (
    input  logic        clk_cpu,
    input  logic        i_rst,
    input  bus_req_t    i_bus,
    output dev_access_t o_acc,
    output logic [7:0]  o_rdata
);

    logic [7:0]  page_q [`SOC_MAP_PAGES];
    logic        cpu_rd;
    logic        cpu_wr;
    logic        map_hit;
    logic        mult_hit;
    logic        timer_hit;
    logic        leds_hit;
    logic [19:0] mapped_addr;

    assign cpu_rd = i_bus.valid && i_bus.rwb;
    assign cpu_wr = i_bus.valid && !i_bus.rwb;

    assign map_hit = (i_bus.addr >= `SOC_MAP_BASE) && (i_bus.addr <= `SOC_MAP_LAST);

    // upper nibble picks a page, the low 12 bits pass straight through
    assign mapped_addr = {page_q[i_bus.addr[15:12]], i_bus.addr[11:0]};

    assign mult_hit  = (mapped_addr >= `SOC_MULT_BASE) && (mapped_addr <= `SOC_MULT_LAST);
    assign timer_hit = (mapped_addr >= `SOC_TIMER_BASE) && (mapped_addr <= `SOC_TIMER_LAST);
    assign leds_hit  = (mapped_addr == `SOC_LEDS_ADDR);

    always_comb begin
        o_acc.sel    = DEV_NONE;
        o_acc.offset = 4'h0;
        o_acc.wdata  = i_bus.wdata;
        o_acc.wr     = cpu_wr;
        o_acc.rd     = cpu_rd;
        if (map_hit) begin
            o_acc.sel    = DEV_MAPPER;    // the window is never translated
            o_acc.offset = i_bus.addr[3:0];
        end else if (mult_hit) begin
            o_acc.sel    = DEV_MULT;
            o_acc.offset = 4'(mapped_addr - `SOC_MULT_BASE);
        end else if (timer_hit) begin
            o_acc.sel    = DEV_TIMER;
            o_acc.offset = 4'(mapped_addr - `SOC_TIMER_BASE);
        end else if (leds_hit) begin
            o_acc.sel    = DEV_LEDS;
        end
    end

    // identity map out of reset so the boot code sees a flat 64 KiB
    always_ff @(posedge clk_cpu) begin
        if (i_rst) begin
            for (int i = 0; i < `SOC_MAP_PAGES; i++) begin
                page_q[i] <= 8'(i);
            end
        end else if (cpu_wr && map_hit) begin
            page_q[i_bus.addr[3:0]] <= i_bus.wdata;
        end
    end

    assign o_rdata = page_q[i_bus.addr[3:0]];    // only returned when sel is DEV_MAPPER

    // an unclaimed strobe must really fall outside the window and every device range
    a_unclaimed_is_open_bus: assert property (
        @(posedge clk_cpu) disable iff (i_rst)
        (o_acc.rd || o_acc.wr) && (o_acc.sel == DEV_NONE) |->
            !map_hit &&
            ((mapped_addr < `SOC_MULT_BASE) || (mapped_addr > `SOC_TIMER_LAST)) &&
            (mapped_addr != `SOC_LEDS_ADDR)
    );

endmodule

`default_nettype wire

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // one strobed 6502-style bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rwb;      // high for a read, low for a write
        logic        valid;
    } bus_req_t;

    typedef enum logic [2:0] {
        DEV_NONE   = 3'd0,
        DEV_MAPPER = 3'd1,
        DEV_MULT   = 3'd2,
        DEV_TIMER  = 3'd3,
        DEV_LEDS   = 3'd4
    } dev_sel_e;

    // decoded access as seen by every peripheral
    typedef struct packed {
        dev_sel_e    sel;
        logic [3:0]  offset;   // register index inside the selected device
        logic [7:0]  wdata;
        logic        wr;       // already qualified by valid
        logic        rd;
    } dev_access_t;

    typedef enum logic [1:0] {
        TMR_IDLE    = 2'd0,
        TMR_RUN     = 2'd1,
        TMR_EXPIRED = 2'd2
    } timer_state_e;

endpackage

`default_nettype wire

// ==== soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

`default_nettype none

// the mapper window sits in the CPU address space and is checked before translation
`define SOC_MAP_BASE    16'h0200
`define SOC_MAP_LAST    16'h020f
`define SOC_MAP_PAGES   16           // one page register per 4 KiB CPU page

// device ranges are compared against the 20-bit mapped address
`define SOC_MULT_BASE   20'h0eff0    // operands at 0..3, product at 4..7
`define SOC_MULT_LAST   20'h0eff7

`define SOC_TIMER_BASE  20'h0eff8    // reload lo, reload hi, control, status
`define SOC_TIMER_LAST  20'h0effb

`define SOC_LEDS_ADDR   20'h0efff

// value seen on a read that no device claims
`define SOC_OPEN_BUS    8'hff

// timer control register bits
`define SOC_TMR_CTRL_EN 0
`define SOC_TMR_CTRL_IE 1
`define SOC_TMR_CTRL_AR 2

`default_nettype wire

`endif
